// ==== sim.f ====
common/ioPkg.sv
memBank/ioMemoryBank.sv
source/ioDispatch.sv
source/ioResponseMerge.sv
source/ioMemorySubsystem.sv
tests/ioMemorySubsystem_chk.sv
tests/ioMemorySubsystemTb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the IO memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f sim.f \
    --top-module ioMemorySubsystemTb \
    -Mdir obj_dir \
    -o ioMemorySubsystemSim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator compile failed with status $status"
    exit 1
fi

# keep running past assertion errors so the testbench prints its summary
output=$(./obj_dir/ioMemorySubsystemSim +verilator+error+limit+100)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Test passed"; then
    exit 0
fi
echo "pass message not found in the simulation output"
exit 1

// ==== tests/ioMemorySubsystemTb.sv ====
`timescale 1ns/100ps

module ioMemorySubsystemTb;
    import ioPkg::*;

    localparam int NumBanks = 4;
    localparam int Depth = 1 << $bits(memAddr_t);
    localparam int ResetCycles = 10;
    localparam int TxCycles = 2000;
    // reset and transaction cycles plus a margin
    localparam int TimeoutCycles = ResetCycles + TxCycles + 490;

    logic     clk;
    logic     rstN;
    logic     clkEn;
    ioReq_t   outReq;
    logic     outAck;
    logic     outReady;
    logic     inReq;
    logic     inAck;
    ioResp_t  inResp;
    logic     flashReadEn;
    bankSel_t flashBank;
    memAddr_t flashAddr;
    memData_t flashData;

    // reference model of every bank, with a mask of written words
    memData_t modelMem [NumBanks][Depth];
    bit       written [NumBanks][Depth];
    logic     enableModel;

    int seed;
    int errorCount = 0;
    int checkCount = 0;
    int cycleCount = 0;

    ioMemorySubsystem #(
        .NumBanks(NumBanks)
    ) ioMemorySubsystem_inst (
        .clk        (clk),
        .rstN       (rstN),
        .clkEn      (clkEn),
        .outReq     (outReq),
        .outAck     (outAck),
        .outReady   (outReady),
        .inReq      (inReq),
        .inAck      (inAck),
        .inResp     (inResp),
        .flashReadEn(flashReadEn),
        .flashBank  (flashBank),
        .flashAddr  (flashAddr),
        .flashData  (flashData)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // the handshake opens on the first edge that sees reset released
    always @(posedge clk) begin
        enableModel <= rstN;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("Timeout: the run did not end within %0d cycles", TimeoutCycles);
            $display("Test failed");
            $finish;
        end
    end

    task automatic compareValue(string name, logic [31:0] expected, logic [31:0] actual);
        checkCount++;
        assert (actual === expected) else begin
            errorCount++;
            $display("[ERROR] %0t %s expected %0h got %0h", $time, name, expected, actual);
        end
    endtask

    task automatic driveRandom();
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        ioReq_t      req;
        bankSel_t    sel;
        memAddr_t    addr;
        r1 = $random(seed);
        r2 = $random(seed);
        r3 = $random(seed);
        // the select is mostly a valid bank and now and then any value
        if (r1[2:0] == 3'd0) begin
            sel = r1[7:3];
        end else begin
            sel = bankSel_t'(int'(r1[7:3]) % NumBanks);
        end
        // a small address pool so that loads hit written words
        addr = (r1[9:8] != 2'b00) ? {7'b0, r1[13:10]} : r1[26:16];
        req.data = {sel, addr, r2[15:0]};
        req.responseRequested = r2[16];
        req.destReg = r2[20:17];
        outReq <= req;
        outAck <= (r2[22:21] != 2'b00);
        inReq <= (r2[24:23] != 2'b00);
        clkEn <= (r2[27:25] != 3'b000);
        flashReadEn <= r2[28];
        if (r3[1:0] == 2'b00) begin
            flashBank <= sel;
        end else if (r3[4:2] == 3'b000) begin
            flashBank <= r3[9:5];
        end else begin
            flashBank <= bankSel_t'(int'(r3[9:5]) % NumBanks);
        end
        flashAddr <= (r3[12:11] != 2'b00) ? {7'b0, r3[16:13]} : r3[27:17];
    endtask

    // outputs are settled by the falling edge
    task automatic verifyCycle();
        bankSel_t sel;
        memAddr_t reqAddr;
        memAddr_t readAddr;
        logic     valid;
        logic     isLoad;
        logic     expReady;
        logic     expInAck;
        logic     doWrite;
        sel = outReq.data[31:27];
        reqAddr = outReq.data[26:16];
        valid = int'(sel) < NumBanks;
        isLoad = outReq.responseRequested;
        expReady = enableModel && valid && (isLoad ? inReq : clkEn);
        expInAck = enableModel && valid && isLoad && inReq && clkEn && outAck;
        doWrite = enableModel && valid && !isLoad && clkEn && outAck;

        compareValue("outReady", 32'(expReady), 32'(outReady));
        compareValue("inAck", 32'(expInAck), 32'(inAck));

        if (expInAck) begin
            compareValue("inResp.regResponseFlag", 32'd1, 32'(inResp.regResponseFlag));
            compareValue("inResp.memResponseFlag", 32'd0, 32'(inResp.memResponseFlag));
            compareValue("inResp.destReg", 32'(outReq.destReg), 32'(inResp.destReg));
            // flash readout takes the read port of its own bank
            readAddr = (flashReadEn && flashBank == sel) ? flashAddr : reqAddr;
            if (written[int'(sel)][readAddr]) begin
                compareValue("inResp.data", {16'h0, modelMem[int'(sel)][readAddr]}, inResp.data);
            end
        end else begin
            checkCount++;
            assert (inResp === '0) else begin
                errorCount++;
                $display("[ERROR] %0t inResp expected 0 got %0h", $time, inResp);
            end
        end

        if (int'(flashBank) < NumBanks) begin
            if (written[int'(flashBank)][flashAddr]) begin
                compareValue("flashData", 32'(modelMem[int'(flashBank)][flashAddr]),
                             32'(flashData));
            end
        end

        // the store lands on the next rising edge
        if (doWrite) begin
            modelMem[int'(sel)][reqAddr] = outReq.data[15:0];
            written[int'(sel)][reqAddr] = 1'b1;
        end
    endtask

    always @(negedge clk) begin
        verifyCycle();
    end

    initial begin
        int assertFails;
        seed = 32'ha6ea;
        rstN = 1'b0;
        clkEn = 1'b0;
        outReq = '0;
        outAck = 1'b0;
        inReq = 1'b0;
        flashReadEn = 1'b0;
        flashBank = '0;
        flashAddr = '0;
        for (int i = 0; i < ResetCycles + TxCycles; i++) begin
            @(posedge clk);
            rstN <= (i >= ResetCycles);
            driveRandom();
        end
        @(posedge clk);
        assertFails = ioMemorySubsystem_inst.ioMemorySubsystemChk_inst.ackFails
                    + ioMemorySubsystem_inst.ioMemorySubsystemChk_inst.enableFails
                    + ioMemorySubsystem_inst.ioMemorySubsystemChk_inst.memFlagFails;
        $display("checks: %0d  errors: %0d  assertion failures: %0d",
                 checkCount, errorCount, assertFails);
        if (errorCount == 0 && assertFails == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== tests/ioMemorySubsystem_chk.sv ====
`timescale 1ns/100ps

module ioMemorySubsystemChk (
    input logic           clk,
    input logic           rstN,
    input logic           clkEn,
    input logic           inReq,
    input logic           inAck,
    input ioPkg::ioResp_t inResp,
    input logic           enableQ
);

    int ackFails = 0;
    int enableFails = 0;
    int memFlagFails = 0;

    // an inbound ack needs the consumer and the clock enable
    inAckNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
        inAck |-> (inReq && clkEn))
        else begin
            ackFails++;
            $error("inAck was high without inReq and clkEn");
        end

    // nothing is acknowledged before the dispatcher opens
    noAckWhileClosed: assert property (@(posedge clk)
        !enableQ |-> !inAck)
        else begin
            enableFails++;
            $error("inAck was high while the dispatcher enable was clear");
        end

    // memory responses are not supported
    noMemResponse: assert property (@(posedge clk)
        !inResp.memResponseFlag)
        else begin
            memFlagFails++;
            $error("memResponseFlag was high");
        end

endmodule

bind ioMemorySubsystem ioMemorySubsystemChk ioMemorySubsystemChk_inst (
    .clk    (clk),
    .rstN   (rstN),
    .clkEn  (clkEn),
    .inReq  (inReq),
    .inAck  (inAck),
    .inResp (inResp),
    .enableQ(ioDispatch_inst.enableQ)
);

// ==== source/ioMemorySubsystem.sv ====
`timescale 1ns/100ps

module ioMemorySubsystem #(
    parameter int NumBanks = 4
) (
    input  logic             clk,
    input  logic             rstN,
    input  logic             clkEn,
    input  ioPkg::ioReq_t    outReq,
    input  logic             outAck,
    output logic             outReady,
    input  logic             inReq,
    output logic             inAck,
    output ioPkg::ioResp_t   inResp,
    input  logic             flashReadEn,
    input  ioPkg::bankSel_t  flashBank,
    input  ioPkg::memAddr_t  flashAddr,
    output ioPkg::memData_t  flashData
);
    import ioPkg::*;

    ioReq_t                   bankReq;
    logic     [NumBanks-1:0]  bankAck;
    logic     [NumBanks-1:0]  bankReady;
    logic     [NumBanks-1:0]  bankInAck;
    logic     [NumBanks-1:0]  bankFlashEn;
    ioResp_t  [NumBanks-1:0]  bankResp;
    memData_t [NumBanks-1:0]  bankFlashData;

    // the 5-bit select field caps the bank count
    if (NumBanks < 1 || NumBanks > MaxBanks) begin : gBadNumBanks
        $error("NumBanks must be between 1 and %0d", MaxBanks);
    end

    ioDispatch #(
        .NumBanks(NumBanks)
    ) ioDispatch_inst (
        .clk      (clk),
        .rstN     (rstN),
        .clkEn    (clkEn),
        .inReq    (inReq),
        .outReq   (outReq),
        .outAck   (outAck),
        .bankReady(bankReady),
        .bankReq  (bankReq),
        .bankAck  (bankAck),
        .outReady (outReady)
    );

    for (genvar i = 0; i < NumBanks; i++) begin : genBank
        // flash enable only reaches the bank it names
        assign bankFlashEn[i] = flashReadEn & (flashBank == bankSel_t'(i));

        ioMemoryBank ioMemoryBank_inst (
            .clk        (clk),
            .clkEn      (clkEn),
            .inReq      (inReq),
            .req        (bankReq),
            .ack        (bankAck[i]),
            .flashReadEn(bankFlashEn[i]),
            .flashAddr  (flashAddr),
            .ready      (bankReady[i]),
            .inAck      (bankInAck[i]),
            .resp       (bankResp[i]),
            .flashData  (bankFlashData[i])
        );
    end

    ioResponseMerge #(
        .NumBanks(NumBanks)
    ) ioResponseMerge_inst (
        .bankResp     (bankResp),
        .bankInAck    (bankInAck),
        .bankFlashData(bankFlashData),
        .flashBank    (flashBank),
        .inResp       (inResp),
        .inAck        (inAck),
        .flashData    (flashData)
    );

endmodule

// ==== source/ioResponseMerge.sv ====
`timescale 1ns/100ps

module ioResponseMerge #(
    parameter int NumBanks = 4
) (
    input  ioPkg::ioResp_t  [NumBanks-1:0] bankResp,
    input  logic            [NumBanks-1:0] bankInAck,
    input  ioPkg::memData_t [NumBanks-1:0] bankFlashData,
    input  ioPkg::bankSel_t                flashBank,
    output ioPkg::ioResp_t                 inResp,
    output logic                           inAck,
    output ioPkg::memData_t                flashData
);
    import ioPkg::*;

    localparam int RespWidth = $bits(ioResp_t);

    // at most one bank acks in a cycle so a plain and-or mux is enough
    always_comb begin
        inResp = '0;
        for (int i = 0; i < NumBanks; i++) begin
            inResp = inResp | (bankResp[i] & {RespWidth{bankInAck[i]}});
        end
    end

    assign inAck = |bankInAck;

    // unknown bank numbers read as zero
    always_comb begin
        flashData = '0;
        for (int i = 0; i < NumBanks; i++) begin
            if (flashBank == bankSel_t'(i)) begin
                flashData = bankFlashData[i];
            end
        end
    end

endmodule

// ==== source/ioDispatch.sv ====
`timescale 1ns/100ps

module ioDispatch #(
    parameter int NumBanks = 4
) (
    input  logic                clk,
    input  logic                rstN,
    input  logic                clkEn,
    input  logic                inReq,
    input  ioPkg::ioReq_t       outReq,
    input  logic                outAck,
    input  logic [NumBanks-1:0] bankReady,
    output ioPkg::ioReq_t       bankReq,
    output logic [NumBanks-1:0] bankAck,
    output logic                outReady
);
    import ioPkg::*;

    logic                enableQ;
    bankSel_t            bankSel;
    logic [NumBanks-1:0] selOneHot;
    logic                selReady;
    logic                consumerOk;

    // held clear through reset, opens on the first edge after release
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            enableQ <= 1'b0;
        end else begin
            enableQ <= 1'b1;
        end
    end

    assign bankSel = getBankSel(outReq.data);

    // a select at or above NumBanks leaves the vector all zero
    always_comb begin
        selOneHot = '0;
        for (int i = 0; i < NumBanks; i++) begin
            selOneHot[i] = (bankSel == bankSel_t'(i));
        end
    end

    assign selReady = |(selOneHot & bankReady);

    // loads also need the inbound consumer, stores only need clkEn
    assign consumerOk = outReq.responseRequested ? inReq : clkEn;

    assign outReady = enableQ & selReady & consumerOk;

    // only the addressed bank sees the ack
    assign bankAck = selOneHot & {NumBanks{outAck & enableQ}};

    // every bank sees the same request word
    assign bankReq = outReq;

endmodule

// ==== memBank/ioMemoryBank.sv ====
`timescale 1ns/100ps

module ioMemoryBank (
    input  logic             clk,
    input  logic             clkEn,
    input  logic             inReq,
    input  ioPkg::ioReq_t    req,
    input  logic             ack,
    input  logic             flashReadEn,
    input  ioPkg::memAddr_t  flashAddr,
    output logic             ready,
    output logic             inAck,
    output ioPkg::ioResp_t   resp,
    output ioPkg::memData_t  flashData
);
    import ioPkg::*;

    localparam int Depth = 1 << $bits(memAddr_t);

    memData_t mem [Depth];

    memAddr_t reqAddr;
    memData_t reqData;
    memAddr_t readAddr;
    memData_t readWord;
    logic     transfer;
    logic     memWriteEn;
    logic     memReadEn;

    assign reqAddr = getAddr(req.data);
    assign reqData = getData(req.data);

    // loads wait for the consumer, stores only for the clock enable
    assign ready = req.responseRequested ? inReq : clkEn;

    assign transfer   = ack & ready & clkEn;
    assign memWriteEn = transfer & ~req.responseRequested;
    assign memReadEn  = transfer & req.responseRequested;

    always_ff @(posedge clk) begin
        if (memWriteEn) begin
            mem[reqAddr] <= reqData;
        end
    end

    // flash readout wins over the load address
    always_comb begin
        case ({flashReadEn, memReadEn})
            2'b01:   readAddr = reqAddr;
            2'b10:   readAddr = flashAddr;
            2'b11:   readAddr = flashAddr;
            default: readAddr = '0;
        endcase
    end

    assign readWord = mem[readAddr];

    // the flash port has its own read path so flashData never waits on a load
    assign flashData = mem[flashAddr];

    assign inAck = memReadEn;

    always_comb begin
        resp.regResponseFlag = memReadEn;
        resp.memResponseFlag = 1'b0;
        resp.destReg         = req.destReg;
        // upper half of the word is zero
        resp.data            = ioWord_t'(readWord);
    end

endmodule

// ==== common/ioPkg.sv ====
package ioPkg;

    // IO word layout
    //   31:27 bank select
    //   26:16 word address
    //   15:0  data
    typedef logic [31:0] ioWord_t;
    typedef logic [10:0] memAddr_t;
    typedef logic [15:0] memData_t;
    typedef logic [3:0]  destReg_t;
    typedef logic [4:0]  bankSel_t;

    // the bank select field can name at most this many banks
    localparam int MaxBanks = 1 << $bits(bankSel_t);

    typedef struct packed {
        logic     responseRequested;
        destReg_t destReg;
        ioWord_t  data;
    } ioReq_t;

    typedef struct packed {
        logic     regResponseFlag;
        logic     memResponseFlag;
        destReg_t destReg;
        ioWord_t  data;
    } ioResp_t;

    function automatic bankSel_t getBankSel(ioWord_t word);
        return word[31:27];
    endfunction

    function automatic memAddr_t getAddr(ioWord_t word);
        return word[26:16];
    endfunction

    function automatic memData_t getData(ioWord_t word);
        return word[15:0];
    endfunction

endpackage
